// ==== Bender.yml ====
package:
  name: exe_stage

sources:
  - source/ExecPkg.sv
  - source/ExeReg.sv
  - source/ForwardUnit.sv
  - source/OperandLane.sv
  - source/Alu.sv
  - source/BranchResolve.sv
  - source/StoreEnable.sv
  - source/ExeStage.sv
  - target: test
    files:
      - testbench/ClockGen.sv
      - testbench/ExeChecker.sv
      - testbench/ExeTb.sv

// ==== flist.f ====
source/ExecPkg.sv
source/ExeReg.sv
source/ForwardUnit.sv
source/OperandLane.sv
source/Alu.sv
source/BranchResolve.sv
source/StoreEnable.sv
source/ExeStage.sv
testbench/ClockGen.sv
testbench/ExeChecker.sv
testbench/ExeTb.sv

// ==== source/Alu.sv ====
// integer ALU
`timescale 1ns/1ns
`default_nettype none

module Alu (
    input  logic [ExecPkg::DataW-1:0]  a,
    input  logic [ExecPkg::DataW-1:0]  b,
    input  ExecPkg::AluOp              aluOp,
    output logic [ExecPkg::DataW-1:0]  result,
    output ExecPkg::ExceptCode         exceptCode
);
    import ExecPkg::*;

    logic [DataW-1:0] sum;
    logic [DataW-1:0] diff;
    logic [4:0]       sa;
    logic             addOvf;
    logic             subOvf;

    assign sum  = a + b;
    assign diff = a - b;
    assign sa   = a[4:0];   // shift amount from lane A

    // same signs in, other sign out
    assign addOvf = (a[DataW-1] == b[DataW-1]) && (sum[DataW-1] != a[DataW-1]);
    // signs differ and result takes b's sign
    assign subOvf = (a[DataW-1] != b[DataW-1]) && (diff[DataW-1] != a[DataW-1]);

    always_comb begin
        case (aluOp)
            Add, Addu: result = sum;
            Sub, Subu: result = diff;
            And:       result = a & b;
            Or:        result = a | b;
            Xor:       result = a ^ b;
            Nor:       result = ~(a | b);
            Slt:       result = {31'b0, $signed(a) < $signed(b)};
            Sltu:      result = {31'b0, a < b};
            Sll:       result = b << sa;
            Srl:       result = b >> sa;
            Sra:       result = $signed(b) >>> sa;
            Lui:       result = b;     // immediate already moved up
            default:   result = '0;
        endcase
    end

    // result still goes out on overflow
    always_comb begin
        if ((aluOp == Add && addOvf) || (aluOp == Sub && subOvf))
            exceptCode = ExcOverflow;
        else
            exceptCode = ExcNone;
    end

endmodule

`default_nettype wire

// ==== source/BranchResolve.sv ====
// conditional branch resolution
`timescale 1ns/1ns
`default_nettype none

module BranchResolve (
    input  ExecPkg::BranchType         branchType,
    input  logic [ExecPkg::DataW-1:0]  busA,
    input  logic [ExecPkg::DataW-1:0]  busB,
    output logic                       branchFlush
);
    import ExecPkg::*;

    logic aZero;
    logic aNeg;

    assign aZero = (busA == '0);
    assign aNeg  = busA[DataW-1];

    always_comb begin
        case (branchType)
            BrEq:    branchFlush = (busA == busB);
            BrNe:    branchFlush = (busA != busB);
            BrGez:   branchFlush = !aNeg;
            BrGtz:   branchFlush = !aNeg && !aZero;
            BrLez:   branchFlush = aNeg || aZero;
            BrLtz:   branchFlush = aNeg;
            default: branchFlush = 1'b0;    // not a branch
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ExeReg.sv ====
// execute stage register
`timescale 1ns/1ns
`default_nettype none

module ExeReg (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          flush,
    input  logic                          wr,
    input  logic [ExecPkg::DataW-1:0]     idBusA,
    input  logic [ExecPkg::DataW-1:0]     idBusB,
    input  logic [ExecPkg::DataW-1:0]     idPc,
    input  ExecPkg::InstrWord             idInstr,
    input  ExecPkg::AluOp                 idAluOp,
    input  logic                          idAluSrcA,
    input  logic                          idAluSrcB,
    input  ExecPkg::DstSel                idDstSel,
    input  ExecPkg::BranchType            idBranchType,
    input  ExecPkg::MemType               idLoadType,
    input  ExecPkg::MemType               idStoreType,
    input  logic                          idRegWr,
    output logic [ExecPkg::DataW-1:0]     exeBusA,
    output logic [ExecPkg::DataW-1:0]     exeBusB,
    output logic [ExecPkg::RegAddrW-1:0]  exeRs,
    output logic [ExecPkg::RegAddrW-1:0]  exeRt,
    output logic [ExecPkg::RegAddrW-1:0]  exeDst,
    output logic [4:0]                    exeShamt,
    output logic [ExecPkg::DataW-1:0]     exeImm32,
    output ExecPkg::AluOp                 exeAluOp,
    output logic                          exeAluSrcA,
    output logic                          exeAluSrcB,
    output ExecPkg::BranchType            exeBranchType,
    output ExecPkg::MemType               exeLoadType,
    output ExecPkg::MemType               exeStoreType,
    output logic                          exeRegWr
);
    import ExecPkg::*;

    InstrWord   instrQ;
    DstSel      dstSelQ;
    logic       linkQ;      // link without branch, A holds return address
    logic       idLink;

    assign idLink = (idDstSel == DstRa) && (idBranchType == BrNone);

    // control state, flush wins over wr
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exeAluOp      <= Addu;  // bubble never traps
            exeBranchType <= BrNone;
            exeLoadType   <= MemNone;
            exeStoreType  <= MemNone;
            exeRegWr      <= 1'b0;
            linkQ         <= 1'b0;
        end else if (flush) begin
            exeAluOp      <= Addu;
            exeBranchType <= BrNone;
            exeLoadType   <= MemNone;
            exeStoreType  <= MemNone;
            exeRegWr      <= 1'b0;
            linkQ         <= 1'b0;
        end else if (wr) begin
            exeAluOp      <= idAluOp;
            exeBranchType <= idBranchType;
            exeLoadType   <= idLoadType;
            exeStoreType  <= idStoreType;
            exeRegWr      <= idRegWr;
            linkQ         <= idLink;
        end
    end

    // payload, holds while wr is low
    always_ff @(posedge clk) begin
        if (wr) begin
            exeBusA    <= idLink ? idPc + 32'd8 : idBusA;
            exeBusB    <= idBusB;
            instrQ     <= idInstr;
            exeAluSrcA <= idAluSrcA;
            exeAluSrcB <= idAluSrcB;
            dstSelQ    <= idDstSel;
        end
    end

    // target bits of a jump are no register, keep them out of bypassing
    assign exeRs    = linkQ ? '0 : instrQ.rFmt.rs;
    assign exeRt    = instrQ.rFmt.rt;
    assign exeShamt = instrQ.rFmt.shamt;

    always_comb begin
        case (exeAluOp)
            And, Or, Xor: exeImm32 = {16'b0, instrQ.iFmt.imm};
            Lui:          exeImm32 = {instrQ.iFmt.imm, 16'b0};
            default:      exeImm32 = {{16{instrQ.iFmt.imm[15]}}, instrQ.iFmt.imm};
        endcase
    end

    always_comb begin
        case (dstSelQ)
            DstRt:   exeDst = instrQ.rFmt.rt;
            DstRa:   exeDst = 5'd31;    // link register
            default: exeDst = instrQ.rFmt.rd;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ExeStage.sv ====
// execute stage top level
`timescale 1ns/1ns
`default_nettype none

module ExeStage (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          flush,
    input  logic                          wr,
    input  logic [ExecPkg::DataW-1:0]     idBusA,
    input  logic [ExecPkg::DataW-1:0]     idBusB,
    input  logic [ExecPkg::DataW-1:0]     idPc,
    input  ExecPkg::InstrWord             idInstr,
    input  ExecPkg::AluOp                 idAluOp,
    input  logic                          idAluSrcA,
    input  logic                          idAluSrcB,
    input  ExecPkg::DstSel                idDstSel,
    input  ExecPkg::BranchType            idBranchType,
    input  ExecPkg::MemType               idLoadType,
    input  ExecPkg::MemType               idStoreType,
    input  logic                          idRegWr,
    input  logic                          memRegWr,
    input  logic [ExecPkg::RegAddrW-1:0]  memDst,
    input  logic [ExecPkg::DataW-1:0]     memResult,
    input  logic                          wbRegWr,
    input  logic [ExecPkg::RegAddrW-1:0]  wbDst,
    input  logic [ExecPkg::DataW-1:0]     wbResult,
    output logic [ExecPkg::DataW-1:0]     aluOut,
    output logic [ExecPkg::RegAddrW-1:0]  dst,
    output logic [ExecPkg::DataW-1:0]     storeData,
    output logic                          regWr,
    output ExecPkg::MemType               loadType,
    output logic [3:0]                    cacheWen,
    output ExecPkg::ExceptCode            exceptCode,
    output logic                          branchFlush
);
    import ExecPkg::*;

    logic [DataW-1:0]     exeBusA;
    logic [DataW-1:0]     exeBusB;
    logic [RegAddrW-1:0]  exeRs;
    logic [RegAddrW-1:0]  exeRt;
    logic [4:0]           exeShamt;
    logic [DataW-1:0]     exeImm32;
    AluOp                 exeAluOp;
    logic                 exeAluSrcA;
    logic                 exeAluSrcB;
    BranchType            exeBranchType;
    MemType               exeStoreType;
    ExceptCode            aluExcept;
    FwdSel                fwdSel [2];
    logic [DataW-1:0]     laneReg [2];
    logic [DataW-1:0]     laneAlt [2];
    logic                 laneAltSel [2];
    logic [DataW-1:0]     bypassed [2];
    logic [DataW-1:0]     operand [2];

    ExeReg uExeReg (
        .clk           (clk),
        .arstN         (arstN),
        .flush         (flush),
        .wr            (wr),
        .idBusA        (idBusA),
        .idBusB        (idBusB),
        .idPc          (idPc),
        .idInstr       (idInstr),
        .idAluOp       (idAluOp),
        .idAluSrcA     (idAluSrcA),
        .idAluSrcB     (idAluSrcB),
        .idDstSel      (idDstSel),
        .idBranchType  (idBranchType),
        .idLoadType    (idLoadType),
        .idStoreType   (idStoreType),
        .idRegWr       (idRegWr),
        .exeBusA       (exeBusA),
        .exeBusB       (exeBusB),
        .exeRs         (exeRs),
        .exeRt         (exeRt),
        .exeDst        (dst),
        .exeShamt      (exeShamt),
        .exeImm32      (exeImm32),
        .exeAluOp      (exeAluOp),
        .exeAluSrcA    (exeAluSrcA),
        .exeAluSrcB    (exeAluSrcB),
        .exeBranchType (exeBranchType),
        .exeLoadType   (loadType),
        .exeStoreType  (exeStoreType),
        .exeRegWr      (regWr)
    );

    ForwardUnit uForwardUnit (
        .exeRs    (exeRs),
        .exeRt    (exeRt),
        .memRegWr (memRegWr),
        .memDst   (memDst),
        .wbRegWr  (wbRegWr),
        .wbDst    (wbDst),
        .fwdSel   (fwdSel)
    );

    // lane A alternate is shamt, lane B the immediate
    assign laneReg[0]    = exeBusA;
    assign laneReg[1]    = exeBusB;
    assign laneAlt[0]    = {{(DataW - 5){1'b0}}, exeShamt};
    assign laneAlt[1]    = exeImm32;
    assign laneAltSel[0] = exeAluSrcA;
    assign laneAltSel[1] = exeAluSrcB;

    for (genvar i = 0; i < 2; i++) begin : gLane
        OperandLane uLane (
            .regValue  (laneReg[i]),
            .memResult (memResult),
            .wbResult  (wbResult),
            .fwdSel    (fwdSel[i]),
            .altValue  (laneAlt[i]),
            .altSel    (laneAltSel[i]),
            .bypassed  (bypassed[i]),
            .operand   (operand[i])
        );
    end

    assign storeData = bypassed[1];     // rt after bypassing

    Alu uAlu (
        .a          (operand[0]),
        .b          (operand[1]),
        .aluOp      (exeAluOp),
        .result     (aluOut),
        .exceptCode (aluExcept)
    );

    BranchResolve uBranchResolve (
        .branchType  (exeBranchType),
        .busA        (bypassed[0]),
        .busB        (bypassed[1]),
        .branchFlush (branchFlush)
    );

    StoreEnable uStoreEnable (
        .addr       (aluOut),
        .loadType   (loadType),
        .storeType  (exeStoreType),
        .aluExcept  (aluExcept),
        .cacheWen   (cacheWen),
        .exceptCode (exceptCode)
    );

endmodule

`default_nettype wire

// ==== source/ExecPkg.sv ====
// execute stage definitions
`default_nettype none

package ExecPkg;

    localparam int RegAddrW = 5;
    localparam int DataW    = 32;

    // register format view
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } RFmt;

    // immediate format view
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } IFmt;

    typedef union packed {
        RFmt rFmt;
        IFmt iFmt;
    } InstrWord;

    // Add and Sub trap on signed overflow
    typedef enum logic [3:0] {
        Add, Addu, Sub, Subu,
        And, Or, Xor, Nor,
        Slt, Sltu,
        Sll, Srl, Sra,
        Lui
    } AluOp;

    typedef enum logic [2:0] {
        BrNone, BrEq, BrNe, BrGez, BrGtz, BrLez, BrLtz
    } BranchType;

    typedef enum logic [1:0] {MemNone, MemByte, MemHalf, MemWord} MemType;

    typedef enum logic [1:0] {ExcNone, ExcOverflow, ExcAdEL, ExcAdES} ExceptCode;

    typedef enum logic [1:0] {DstRd, DstRt, DstRa} DstSel;

    typedef enum logic [1:0] {FwdReg, FwdMem, FwdWb} FwdSel;

endpackage

`default_nettype wire

// ==== source/ForwardUnit.sv ====
// bypass source selection
`timescale 1ns/1ns
`default_nettype none

module ForwardUnit (
    input  logic [ExecPkg::RegAddrW-1:0]  exeRs,
    input  logic [ExecPkg::RegAddrW-1:0]  exeRt,
    input  logic                          memRegWr,
    input  logic [ExecPkg::RegAddrW-1:0]  memDst,
    input  logic                          wbRegWr,
    input  logic [ExecPkg::RegAddrW-1:0]  wbDst,
    output ExecPkg::FwdSel                fwdSel [2]
);
    import ExecPkg::*;

    logic [RegAddrW-1:0] src [2];

    assign src[0] = exeRs;
    assign src[1] = exeRt;

    // memory stage is younger, so it wins over write-back
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (memRegWr && src[i] != '0 && memDst == src[i])
                fwdSel[i] = FwdMem;
            else if (wbRegWr && src[i] != '0 && wbDst == src[i])
                fwdSel[i] = FwdWb;
            else
                fwdSel[i] = FwdReg;     // r0 always reads zero
        end
    end

endmodule

`default_nettype wire

// ==== source/OperandLane.sv ====
// one ALU operand lane
`timescale 1ns/1ns
`default_nettype none

module OperandLane (
    input  logic [ExecPkg::DataW-1:0]  regValue,
    input  logic [ExecPkg::DataW-1:0]  memResult,
    input  logic [ExecPkg::DataW-1:0]  wbResult,
    input  ExecPkg::FwdSel             fwdSel,
    input  logic [ExecPkg::DataW-1:0]  altValue,
    input  logic                       altSel,
    output logic [ExecPkg::DataW-1:0]  bypassed,
    output logic [ExecPkg::DataW-1:0]  operand
);
    import ExecPkg::*;

    // first level, bypass
    always_comb begin
        case (fwdSel)
            FwdMem:  bypassed = memResult;
            FwdWb:   bypassed = wbResult;
            default: bypassed = regValue;
        endcase
    end

    // second level, shamt or immediate instead
    assign operand = altSel ? altValue : bypassed;

endmodule

`default_nettype wire

// ==== source/StoreEnable.sv ====
// data cache write mask and alignment
`timescale 1ns/1ns
`default_nettype none

module StoreEnable (
    input  logic [ExecPkg::DataW-1:0]  addr,
    input  ExecPkg::MemType            loadType,
    input  ExecPkg::MemType            storeType,
    input  ExecPkg::ExceptCode         aluExcept,
    output logic [3:0]                 cacheWen,
    output ExecPkg::ExceptCode         exceptCode
);
    import ExecPkg::*;

    logic loadMis;
    logic storeMis;

    assign loadMis  = (loadType == MemHalf && addr[0]) ||
                      (loadType == MemWord && addr[1:0] != 2'b00);
    assign storeMis = (storeType == MemHalf && addr[0]) ||
                      (storeType == MemWord && addr[1:0] != 2'b00);

    // ALU exception came first and wins
    always_comb begin
        if (aluExcept != ExcNone) exceptCode = aluExcept;
        else if (loadMis)         exceptCode = ExcAdEL;
        else if (storeMis)        exceptCode = ExcAdES;
        else                      exceptCode = ExcNone;
    end

    always_comb begin
        cacheWen = 4'b0000;
        if (exceptCode == ExcNone) begin
            case (storeType)
                MemByte: cacheWen = 4'b0001 << addr[1:0];
                MemHalf: cacheWen = addr[1] ? 4'b1100 : 4'b0011;
                MemWord: cacheWen = 4'b1111;
                default: cacheWen = 4'b0000;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== testbench/ClockGen.sv ====
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module ClockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/ExeChecker.sv ====
// execute stage output checker
`timescale 1ns/1ns
`default_nettype none

module ExeChecker (
    input  logic        clk,
    input  logic        checkEn,
    input  logic        flagsOnly,
    input  logic [63:0] caseName,
    input  logic [31:0] expAluOut,
    input  logic [4:0]  expDst,
    input  logic [31:0] expStoreData,
    input  logic [15:0] expFlags,
    input  logic [1:0]  expLoadType,
    input  logic [31:0] aluOut,
    input  logic [4:0]  dst,
    input  logic [31:0] storeData,
    input  logic        regWr,
    input  logic [1:0]  loadType,
    input  logic [3:0]  cacheWen,
    input  logic [1:0]  exceptCode,
    input  logic        branchFlush,
    output int          passCount,
    output int          failCount
);

    logic [15:0] actFlags;

    // same nibble layout as the case file
    assign actFlags = {3'b0, regWr, cacheWen, 2'b0, exceptCode, 3'b0, branchFlush};

    initial begin
        passCount = 0;
        failCount = 0;
    end

    task automatic compareField(input string field, input logic [31:0] expVal,
                                input logic [31:0] actVal, inout int errs);
        if (actVal !== expVal) begin
            $display("** Error %0s: %0s expected %h actual %h",
                     caseName, field, expVal, actVal);
            errs++;
        end
    endtask

    // outputs settled with wr low and bypass held
    always @(posedge clk) begin
        int errs;
        errs = 0;
        if (checkEn) begin
            compareField("flags", {16'b0, expFlags}, {16'b0, actFlags}, errs);
            compareField("loadType", {30'b0, expLoadType}, {30'b0, loadType}, errs);
            if (!flagsOnly) begin
                compareField("aluOut", expAluOut, aluOut, errs);
                compareField("dst", {27'b0, expDst}, {27'b0, dst}, errs);
                compareField("storeData", expStoreData, storeData, errs);
            end
            if (errs == 0) begin
                passCount++;
                $display("case %0s ok", caseName);
            end else begin
                failCount++;
                $display("case %0s had %0d mismatches", caseName, errs);
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/ExeTb.sv ====
// execute stage testbench
`timescale 1ns/1ns
`default_nettype none

module ExeTb;
    import ExecPkg::*;

    localparam int MaxCases = 64;

    logic clk, arstN, flush, wr;
    logic [31:0] idBusA, idBusB, idPc;
    InstrWord idInstr;
    AluOp idAluOp;
    logic idAluSrcA, idAluSrcB, idRegWr;
    DstSel idDstSel;
    BranchType idBranchType;
    MemType idLoadType, idStoreType;
    logic memRegWr, wbRegWr;
    logic [4:0] memDst, wbDst;
    logic [31:0] memResult, wbResult;
    logic [31:0] aluOut, storeData;
    logic [4:0] dst;
    logic regWr, branchFlush;
    MemType loadType;
    logic [3:0] cacheWen;
    ExceptCode exceptCode;

    logic checkEn, flagsOnly, loaded, loadOk;
    logic [63:0] caseName;
    logic [31:0] expAluOut, expStoreData;
    logic [4:0] expDst;
    logic [15:0] expFlags;
    logic [1:0] expLoadType;
    int passCount, failCount, nCases;

    // case table with the data file's columns
    logic [63:0] names [MaxCases];
    logic [31:0] tMode [MaxCases], tA [MaxCases], tB [MaxCases], tInstr [MaxCases];
    logic [31:0] tCtl [MaxCases], tByp [MaxCases], tMres [MaxCases], tWres [MaxCases];
    logic [31:0] tAlu [MaxCases], tDst [MaxCases], tSd [MaxCases], tFlg [MaxCases];

    ClockGen uClockGen (.clk(clk), .arstN(arstN));

    ExeStage i_ExeStage (
        .clk(clk), .arstN(arstN), .flush(flush), .wr(wr),
        .idBusA(idBusA), .idBusB(idBusB), .idPc(idPc), .idInstr(idInstr),
        .idAluOp(idAluOp), .idAluSrcA(idAluSrcA), .idAluSrcB(idAluSrcB),
        .idDstSel(idDstSel), .idBranchType(idBranchType), .idLoadType(idLoadType),
        .idStoreType(idStoreType), .idRegWr(idRegWr),
        .memRegWr(memRegWr), .memDst(memDst), .memResult(memResult),
        .wbRegWr(wbRegWr), .wbDst(wbDst), .wbResult(wbResult),
        .aluOut(aluOut), .dst(dst), .storeData(storeData), .regWr(regWr),
        .loadType(loadType), .cacheWen(cacheWen), .exceptCode(exceptCode),
        .branchFlush(branchFlush)
    );

    ExeChecker uExeChecker (
        .clk(clk), .checkEn(checkEn), .flagsOnly(flagsOnly), .caseName(caseName),
        .expAluOut(expAluOut), .expDst(expDst), .expStoreData(expStoreData),
        .expFlags(expFlags), .expLoadType(expLoadType), .aluOut(aluOut), .dst(dst),
        .storeData(storeData), .regWr(regWr), .loadType(loadType),
        .cacheWen(cacheWen), .exceptCode(exceptCode),
        .branchFlush(branchFlush), .passCount(passCount), .failCount(failCount)
    );

    task automatic readCases();
        int fd;
        int n;
        string line;
        fd = $fopen("testbench/exeCases.dat", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            loadOk = 1'b0;
        end else begin
            while (!$feof(fd) && nCases < MaxCases) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 2 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                                names[nCases], tMode[nCases], tA[nCases], tB[nCases],
                                tInstr[nCases], tCtl[nCases], tByp[nCases],
                                tMres[nCases], tWres[nCases], tAlu[nCases],
                                tDst[nCases], tSd[nCases], tFlg[nCases]);
                    if (n != 13) begin
                        $display("malformed line in the case file: %0s", line);
                        loadOk = 1'b0;
                    end
                    nCases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic driveCase(input int k);
        caseName     = names[k];
        flagsOnly    = (tMode[k] == 3);
        flush        = (tMode[k] == 1);
        wr           = (tMode[k] < 2);      // stall and idle hold the register
        idBusA       = tA[k];
        idBusB       = tB[k];
        idInstr      = tInstr[k];
        idAluOp      = AluOp'(tCtl[k][31:28]);
        idAluSrcA    = tCtl[k][24];
        idAluSrcB    = tCtl[k][20];
        idDstSel     = DstSel'(tCtl[k][17:16]);
        idBranchType = BranchType'(tCtl[k][14:12]);
        idLoadType   = MemType'(tCtl[k][9:8]);
        idStoreType  = MemType'(tCtl[k][5:4]);
        idRegWr      = tCtl[k][0];
        memRegWr     = tByp[k][20];
        memDst       = tByp[k][16:12];
        wbRegWr      = tByp[k][8];
        wbDst        = tByp[k][4:0];
        memResult    = tMres[k];
        wbResult     = tWres[k];
        expAluOut    = tAlu[k];
        expDst       = tDst[k][4:0];
        expStoreData = tSd[k];
        expFlags     = tFlg[k][15:0];
        if (tMode[k] == 0)
            expLoadType = tCtl[k][9:8];     // captured on the next edge
        else if (tMode[k] == 1)
            expLoadType = MemNone;          // bubble after flush
    endtask

    initial begin
        flush        = 0;
        wr           = 0;
        idBusA       = '0;
        idBusB       = '0;
        idPc         = 32'h0000_0400;
        idInstr      = '0;
        idAluOp      = Addu;
        idAluSrcA    = 0;
        idAluSrcB    = 0;
        idRegWr      = 0;
        idDstSel     = DstRd;
        idBranchType = BrNone;
        idLoadType   = MemNone;
        idStoreType  = MemNone;
        memRegWr     = 0;
        memDst       = '0;
        memResult    = '0;
        wbRegWr      = 0;
        wbDst        = '0;
        wbResult     = '0;
        checkEn      = 0;
        flagsOnly    = 0;
        caseName     = '0;
        expAluOut    = '0;
        expDst       = '0;
        expStoreData = '0;
        expFlags     = '0;
        expLoadType  = MemNone;     // reset bubble
        nCases       = 0;
        loaded       = 0;
        loadOk       = 1;
        readCases();
        loaded = 1'b1;
        if (!loadOk || nCases == 0) begin
            $display("no usable cases were loaded");
            $display("Simulation failed");
            $finish;
        end else begin
            wait (arstN);
            for (int k = 0; k < nCases; k++) begin
                @(negedge clk);
                checkEn = 1'b0;
                driveCase(k);
                @(negedge clk);
                wr      = 1'b0;     // hold while the checker samples
                flush   = 1'b0;
                checkEn = 1'b1;
            end
            @(negedge clk);
            checkEn = 1'b0;
            @(negedge clk);
            $display("cases passed %0d failed %0d", passCount, failCount);
            if (failCount == 0 && passCount == nCases) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // watchdog allows two cycles per case plus margin
    initial begin
        wait (loaded);
        #((nCases + 10) * 2 * 100);
        $display("timeout, the cases did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/exeCases.dat ====
# name mode(0 run 1 flush 2 stall 3 idle) busA busB instr ctl byp memResult wbResult
# expected: aluOut dst storeData flags{regWr,cacheWen,exc,branchFlush}
rst     3 00000000 00000000 00000000 00000000 000000 00000000 00000000 00000000 00 00000000 0000
add     0 00000005 00000007 00221800 00000001 000000 00000000 00000000 0000000c 03 00000007 1000
addovf  0 7fffffff 00000001 00221800 00000001 000000 00000000 00000000 80000000 03 00000001 1010
addu    0 7fffffff 00000001 00221800 10000001 000000 00000000 00000000 80000000 03 00000001 1000
subovf  0 80000000 00000001 00221800 20000001 000000 00000000 00000000 7fffffff 03 00000001 1010
subu    0 80000000 00000001 00221800 30000001 000000 00000000 00000000 7fffffff 03 00000001 1000
and     0 f0f0ff00 0ff0f0f0 00221800 40000001 000000 00000000 00000000 00f0f000 03 0ff0f0f0 1000
or      0 f0f0ff00 0ff0f0f0 00221800 50000001 000000 00000000 00000000 fff0fff0 03 0ff0f0f0 1000
xor     0 f0f0ff00 0ff0f0f0 00221800 60000001 000000 00000000 00000000 ff000ff0 03 0ff0f0f0 1000
nor     0 f0f0ff00 0ff0f0f0 00221800 70000001 000000 00000000 00000000 000f000f 03 0ff0f0f0 1000
slt     0 ffffffff 00000001 00221800 80000001 000000 00000000 00000000 00000001 03 00000001 1000
sltu    0 ffffffff 00000001 00221800 90000001 000000 00000000 00000000 00000000 03 00000001 1000
sll     0 00000000 0000000f 00221900 a1000001 000000 00000000 00000000 000000f0 03 0000000f 1000
srl     0 00000000 80000000 00221900 b1000001 000000 00000000 00000000 08000000 03 80000000 1000
sra     0 00000000 80000000 00221900 c1000001 000000 00000000 00000000 f8000000 03 80000000 1000
lui     0 00000000 00000000 00221234 d0110001 000000 00000000 00000000 12340000 02 00000000 1000
andi    0 ffffffff 00000000 00228001 40110001 000000 00000000 00000000 00008001 02 00000000 1000
addi    0 00000001 00000000 00228001 00110001 000000 00000000 00000000 ffff8002 02 00000000 1000
fwdmem  0 00000001 00000002 00221800 00000001 101101 00000100 00000200 00000102 03 00000002 1000
fwdwb   0 00000001 00000002 00221800 00000001 000102 00000100 00000200 00000201 03 00000200 1000
fwdr0   0 00000005 00000006 00021800 00000001 100100 00000100 00000200 0000000b 03 00000006 1000
sdfwd   0 00001000 00000002 00220004 00110030 102000 deadbeef 00000000 00001004 02 deadbeef 0f00
sb0     0 00001000 aabbccdd 00220000 00110010 000000 00000000 00000000 00001000 02 aabbccdd 0100
sb1     0 00001000 aabbccdd 00220001 00110010 000000 00000000 00000000 00001001 02 aabbccdd 0200
sb2     0 00001000 aabbccdd 00220002 00110010 000000 00000000 00000000 00001002 02 aabbccdd 0400
sb3     0 00001000 aabbccdd 00220003 00110010 000000 00000000 00000000 00001003 02 aabbccdd 0800
sh0     0 00001000 aabbccdd 00220000 00110020 000000 00000000 00000000 00001000 02 aabbccdd 0300
sh2     0 00001000 aabbccdd 00220002 00110020 000000 00000000 00000000 00001002 02 aabbccdd 0c00
sh1     0 00001000 aabbccdd 00220001 00110020 000000 00000000 00000000 00001001 02 aabbccdd 0030
sw2     0 00001000 aabbccdd 00220002 00110030 000000 00000000 00000000 00001002 02 aabbccdd 0030
lw1     0 00001000 00000000 00220001 00110301 000000 00000000 00000000 00001001 02 00000000 1020
lh3     0 00001000 00000000 00220003 00110201 000000 00000000 00000000 00001003 02 00000000 1020
beqT    0 00000005 00000005 00221800 10001000 000000 00000000 00000000 0000000a 03 00000005 0001
beqN    0 00000005 00000006 00221800 10001000 000000 00000000 00000000 0000000b 03 00000006 0000
bneT    0 00000005 00000006 00221800 10002000 000000 00000000 00000000 0000000b 03 00000006 0001
bgezT   0 00000000 00000000 00221800 10003000 000000 00000000 00000000 00000000 03 00000000 0001
bgtzN   0 00000000 00000000 00221800 10004000 000000 00000000 00000000 00000000 03 00000000 0000
blezT   0 ffffffff 00000000 00221800 10005000 000000 00000000 00000000 ffffffff 03 00000000 0001
bltzN   0 00000001 00000000 00221800 10006000 000000 00000000 00000000 00000001 03 00000000 0000
beqFwd  0 00000001 00000009 00221800 10001000 101000 00000009 00000000 00000012 03 00000009 0001
pre     0 00000002 00000003 00221800 00000001 000000 00000000 00000000 00000005 03 00000003 1000
stall   2 00000100 00000200 00221800 50000031 000000 00000000 00000000 00000005 03 00000003 1000
flush   1 00000005 00000006 00221800 00000031 000000 00000000 00000000 0000000b 03 00000006 0000
